// ==== common/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// ---------------------------------------------------------------------------
// Data path geometry
// ---------------------------------------------------------------------------

// Data and address width
`define XLEN 32

// Architectural registers x0 to x31
`define NUM_REGS 32
`define REG_IDX_W 5

// ---------------------------------------------------------------------------
// Fetch
// ---------------------------------------------------------------------------

// One word per instruction
`define PC_STEP 4

// addi x0, x0, 0
`define NOP_INSN 32'h0000_0013

`endif

// ==== common/isaPkg.sv ====
`default_nettype none
`include "cpu_consts.svh"

package isaPkg;

    // Basic data types
    typedef logic [`XLEN-1:0]      word_t;    // Data or address
    typedef logic [`REG_IDX_W-1:0] regIdx_t;  // Register index

    // Major opcodes kept from RV32I
    typedef enum logic [6:0] {
        opLoad  = 7'b0000011,  // LW
        opImm   = 7'b0010011,  // ADDI and friends
        opStore = 7'b0100011,  // SW
        opReg   = 7'b0110011   // R-type ALU
    } opcode_t;

    // ALU operations
    // Encoded as {insn[30], funct3} where that makes sense
    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSll  = 4'b0001,
        aluSlt  = 4'b0010,  // Signed compare
        aluSltu = 4'b0011,  // Unsigned compare
        aluXor  = 4'b0100,
        aluSrl  = 4'b0101,
        aluOr   = 4'b0110,
        aluAnd  = 4'b0111,
        aluSub  = 4'b1000,
        aluSra  = 4'b1101
    } aluOp_t;

endpackage

`default_nettype wire

// ==== common/pipePkg.sv ====
`default_nettype none

package pipePkg;

    // Source of an execute-stage operand
    typedef enum logic [1:0] {
        fwdNone = 2'b00,  // Register file value from decode
        fwdWb   = 2'b01,  // Write-back value
        fwdMem  = 2'b10   // ALU result sitting in memory stage
    } fwdSel_t;

endpackage

`default_nettype wire

// ==== execute/alu.sv ====
`default_nettype none

module alu (
    input  isaPkg::word_t  a,
    input  isaPkg::word_t  b,
    input  logic [4:0]     shamt,
    input  isaPkg::aluOp_t op,
    output isaPkg::word_t  result
);
    import isaPkg::*;

    logic ltSigned;
    logic ltUnsigned;

    // Compare results for SLT and SLTU
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (op)
            // Arithmetic
            aluAdd:  result = a + b;
            aluSub:  result = a - b;

            // Compares give 0 or 1
            aluSlt:  result = word_t'(ltSigned);
            aluSltu: result = word_t'(ltUnsigned);

            // Shifts by five-bit amount
            aluSll:  result = a << shamt;
            aluSrl:  result = a >> shamt;
            aluSra:  result = $unsigned($signed(a) >>> shamt);  // Sign fill

            // Logic
            aluXor:  result = a ^ b;
            aluOr:   result = a | b;
            aluAnd:  result = a & b;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== execute/executeStage.sv ====
`default_nettype none

module executeStage (
    input  logic             clk,
    input  logic             rst_n,
    input  isaPkg::regIdx_t  exRd,
    input  logic             exRegWrite,
    input  logic             exMemRead,
    input  logic             exMemWrite,
    input  logic             exUseImm,
    input  isaPkg::aluOp_t   exAluOp,
    input  isaPkg::word_t    exImm,
    input  logic [4:0]       exShamt,
    input  isaPkg::word_t    exRs1Data,
    input  isaPkg::word_t    exRs2Data,
    input  pipePkg::fwdSel_t fwdA,
    input  pipePkg::fwdSel_t fwdB,
    input  isaPkg::word_t    wbData,
    output isaPkg::word_t    memAluResult,
    output isaPkg::word_t    memStoreData,
    output isaPkg::regIdx_t  memRd,
    output logic             memRegWrite,
    output logic             memMemRead,
    output logic             memMemWrite
);
    import isaPkg::*;
    import pipePkg::*;

    word_t      opA;
    word_t      rs2Fwd;     // Forwarded rs2 and store data
    word_t      opB;
    logic [4:0] shamt;
    word_t      aluResult;

    function automatic word_t pickOperand(input fwdSel_t sel, input word_t regVal,
                                          input word_t memVal, input word_t wbVal);
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    // ---------------------------------------------------------------------------
    // Operand select
    // ---------------------------------------------------------------------------
    assign opA    = pickOperand(fwdA, exRs1Data, memAluResult, wbData);
    assign rs2Fwd = pickOperand(fwdB, exRs2Data, memAluResult, wbData);
    assign opB    = exUseImm ? exImm : rs2Fwd;

    // Register shifts use the low bits of rs2
    assign shamt = exUseImm ? exShamt : opB[4:0];

    alu aluInst (
        .a(opA),
        .b(opB),
        .shamt(shamt),
        .op(exAluOp),
        .result(aluResult)
    );

    // ---------------------------------------------------------------------------
    // Execute to memory register
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            memRegWrite <= 1'b0;
            memMemRead  <= 1'b0;
            memMemWrite <= 1'b0;
        end else begin
            memRegWrite <= exRegWrite;
            memMemRead  <= exMemRead;
            memMemWrite <= exMemWrite;
        end
    end

    always_ff @(posedge clk) begin
        memAluResult <= aluResult;  // Also the mem-stage forward source
        memStoreData <= rs2Fwd;
        memRd        <= exRd;
    end

endmodule

`default_nettype wire

// ==== decode/regFile.sv ====
`default_nettype none
`include "cpu_consts.svh"

module regFile (
    input  logic            clk,
    input  logic            rst_n,
    input  isaPkg::regIdx_t rs1,
    input  isaPkg::regIdx_t rs2,
    output isaPkg::word_t   rs1Data,
    output isaPkg::word_t   rs2Data,
    input  logic            wrEn,
    input  isaPkg::regIdx_t wrIdx,
    input  isaPkg::word_t   wrData
);
    import isaPkg::*;

    word_t regs [`NUM_REGS];

    // Architectural state starts at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrIdx != '0) begin  // x0 never written
            regs[wrIdx] <= wrData;
        end
    end

    // Write-through so decode sees this cycle's write-back
    assign rs1Data = (rs1 == '0) ? '0 : (wrEn && wrIdx == rs1) ? wrData : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : (wrEn && wrIdx == rs2) ? wrData : regs[rs2];

endmodule

`default_nettype wire

// ==== decode/decodeStage.sv ====
`default_nettype none
`include "cpu_consts.svh"

module decodeStage (
    input  logic            clk,
    input  logic            rst_n,
    input  isaPkg::word_t   insn,
    input  isaPkg::word_t   insnPc,
    input  logic            stall,
    input  logic            wbRegWrite,
    input  isaPkg::regIdx_t wbRd,
    input  isaPkg::word_t   wbData,
    output isaPkg::regIdx_t rs1Id,
    output isaPkg::regIdx_t rs2Id,
    output isaPkg::regIdx_t exRs1,
    output isaPkg::regIdx_t exRs2,
    output isaPkg::regIdx_t exRd,
    output logic            exRegWrite,
    output logic            exMemRead,
    output logic            exMemWrite,
    output logic            exUseImm,
    output isaPkg::aluOp_t  exAluOp,
    output isaPkg::word_t   exImm,
    output logic [4:0]      exShamt,
    output isaPkg::word_t   exRs1Data,
    output isaPkg::word_t   exRs2Data
);
    import isaPkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      immI, immS;
    word_t      rs1Data, rs2Data;

    // Decoded control
    logic       regWrite, memRead, memWrite, useImm;
    aluOp_t     aluOp;
    word_t      imm;
    logic       isWord;  // funct3 of LW and SW

    function automatic aluOp_t aluFor(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? aluSub : aluAdd;
            3'b001:  return aluSll;
            3'b010:  return aluSlt;
            3'b011:  return aluSltu;
            3'b100:  return aluXor;
            3'b101:  return alt ? aluSra : aluSrl;
            3'b110:  return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    assign rs1Id  = insn[19:15];
    assign rs2Id  = insn[24:20];
    assign funct3 = insn[14:12];
    assign funct7 = insn[31:25];
    assign isWord = (funct3 == 3'b010);

    // Sign-extended immediates
    assign immI = {{(`XLEN-12){insn[31]}}, insn[31:20]};
    assign immS = {{(`XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};

    always_comb begin
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        useImm   = 1'b0;
        aluOp    = aluAdd;  // Address add for LW and SW
        imm      = immI;
        case (insn[6:0])
            opImm: begin
                regWrite = 1'b1;
                useImm   = 1'b1;
                aluOp    = aluFor(funct3, funct7[5] && funct3 == 3'b101);  // Bit 30 only for SRAI
            end
            opReg: begin
                regWrite = 1'b1;
                aluOp    = aluFor(funct3, funct7[5]);
            end
            opLoad: begin
                regWrite = isWord;
                memRead  = isWord;
                useImm   = 1'b1;
            end
            opStore: begin
                memWrite = isWord;
                useImm   = 1'b1;
                imm      = immS;
            end
            default: ;  // Unknown opcode gives a bubble
        endcase
    end

    regFile regFileInst (
        .clk(clk), .rst_n(rst_n),
        .rs1(rs1Id), .rs2(rs2Id), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .wrEn(wbRegWrite), .wrIdx(wbRd), .wrData(wbData)
    );

    // Control half of the decode to execute register
    // Bubble on load-use stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
        end else begin
            exRegWrite <= regWrite && !stall;
            exMemRead  <= memRead && !stall;
            exMemWrite <= memWrite && !stall;
        end
    end

    // Payload half
    always_ff @(posedge clk) begin
        exRs1     <= rs1Id;
        exRs2     <= rs2Id;
        exRd      <= insn[11:7];
        exUseImm  <= useImm;
        exAluOp   <= aluOp;
        exImm     <= imm;
        exShamt   <= insn[24:20];  // I-type shift amount
        exRs1Data <= rs1Data;
        exRs2Data <= rs2Data;
    end

endmodule

`default_nettype wire

// ==== rtl/hazardUnit.sv ====
`default_nettype none

module hazardUnit (
    input  isaPkg::regIdx_t  rs1Id,
    input  isaPkg::regIdx_t  rs2Id,
    input  isaPkg::regIdx_t  exRd,
    input  logic             exMemRead,
    input  isaPkg::regIdx_t  exRs1,
    input  isaPkg::regIdx_t  exRs2,
    input  isaPkg::regIdx_t  memRd,
    input  logic             memRegWrite,
    input  isaPkg::regIdx_t  wbRd,
    input  logic             wbRegWrite,
    output logic             stall,
    output pipePkg::fwdSel_t fwdA,
    output pipePkg::fwdSel_t fwdB
);
    import isaPkg::*;
    import pipePkg::*;

    // Memory stage wins over write-back
    function automatic fwdSel_t pickSource(input regIdx_t rs, input regIdx_t mRd,
                                           input logic mWr, input regIdx_t wRd,
                                           input logic wWr);
        if (mWr && mRd != '0 && mRd == rs) return fwdMem;
        if (wWr && wRd != '0 && wRd == rs) return fwdWb;
        return fwdNone;
    endfunction

    assign fwdA = pickSource(exRs1, memRd, memRegWrite, wbRd, wbRegWrite);
    assign fwdB = pickSource(exRs2, memRd, memRegWrite, wbRd, wbRegWrite);

    // Load in execute feeding the instruction in decode
    assign stall = exMemRead && exRd != '0 && (exRd == rs1Id || exRd == rs2Id);

endmodule

`default_nettype wire

// ==== rtl/memStage.sv ====
`default_nettype none

module memStage (
    input  logic            clk,
    input  logic            rst_n,
    input  isaPkg::word_t   memAluResult,
    input  isaPkg::word_t   memStoreData,
    input  isaPkg::regIdx_t memRd,
    input  logic            memRegWrite,
    input  logic            memMemRead,
    input  logic            memMemWrite,
    output isaPkg::word_t   dmemAddr,
    output isaPkg::word_t   dmemWData,
    output logic            dmemWen,
    input  isaPkg::word_t   dmemRData,
    output isaPkg::word_t   wbData,
    output isaPkg::regIdx_t wbRd,
    output logic            wbRegWrite
);
    import isaPkg::*;

    word_t wbNext;

    // Data memory port
    assign dmemAddr  = memAluResult;  // Effective address from ALU
    assign dmemWData = memStoreData;
    assign dmemWen   = memMemWrite;   // Write at the closing edge

    // Write-back select ahead of the register
    assign wbNext = memMemRead ? dmemRData : memAluResult;

    // ---------------------------------------------------------------------------
    // Memory to write-back register
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wbRegWrite <= 1'b0;
        end else begin
            wbRegWrite <= memRegWrite;
        end
    end

    always_ff @(posedge clk) begin
        wbData <= wbNext;  // Load data or ALU result
        wbRd   <= memRd;
    end

endmodule

`default_nettype wire

// ==== rtl/cpuCore.sv ====
`default_nettype none
`include "cpu_consts.svh"

module cpuCore (
    input  logic          clk,
    input  logic          rst_n,
    output isaPkg::word_t imemAddr,
    input  isaPkg::word_t imemInsn,
    output isaPkg::word_t dmemAddr,
    output isaPkg::word_t dmemWData,
    output logic          dmemWen,
    input  isaPkg::word_t dmemRData
);
    import isaPkg::*;
    import pipePkg::*;

    // Fetch
    word_t   pc;
    word_t   ifInsn;        // Fetch register
    word_t   ifPc;

    // Decode outputs
    regIdx_t rs1Id, rs2Id;  // Live indices for hazard check
    regIdx_t exRs1, exRs2, exRd;
    logic    exRegWrite, exMemRead, exMemWrite, exUseImm;
    aluOp_t  exAluOp;
    word_t   exImm;
    logic [4:0] exShamt;
    word_t   exRs1Data, exRs2Data;

    // Execute to memory
    word_t   memAluResult, memStoreData;
    regIdx_t memRd;
    logic    memRegWrite, memMemRead, memMemWrite;

    // Write-back
    word_t   wbData;
    regIdx_t wbRd;
    logic    wbRegWrite;

    // Hazard control
    logic    stall;
    fwdSel_t fwdA, fwdB;

    // ---------------------------------------------------------------------------
    // Fetch stage
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= '0;
            ifInsn <= `NOP_INSN;       // Start with a harmless NOP
            ifPc   <= '0;
        end else if (!stall) begin    // Freeze on load-use
            pc     <= pc + `PC_STEP;
            ifInsn <= imemInsn;
            ifPc   <= pc;
        end
    end

    assign imemAddr = pc;  // Memory answers in the same cycle

    // ---------------------------------------------------------------------------
    // Later stages
    // ---------------------------------------------------------------------------
    decodeStage decodeInst (
        .clk(clk), .rst_n(rst_n),
        .insn(ifInsn), .insnPc(ifPc), .stall(stall),
        .wbRegWrite(wbRegWrite), .wbRd(wbRd), .wbData(wbData),
        .rs1Id(rs1Id), .rs2Id(rs2Id),
        .exRs1(exRs1), .exRs2(exRs2), .exRd(exRd),
        .exRegWrite(exRegWrite), .exMemRead(exMemRead),
        .exMemWrite(exMemWrite), .exUseImm(exUseImm),
        .exAluOp(exAluOp), .exImm(exImm), .exShamt(exShamt),
        .exRs1Data(exRs1Data), .exRs2Data(exRs2Data)
    );

    hazardUnit hazardInst (
        .rs1Id(rs1Id), .rs2Id(rs2Id), .exRd(exRd), .exMemRead(exMemRead),
        .exRs1(exRs1), .exRs2(exRs2),
        .memRd(memRd), .memRegWrite(memRegWrite),
        .wbRd(wbRd), .wbRegWrite(wbRegWrite),
        .stall(stall), .fwdA(fwdA), .fwdB(fwdB)
    );

    executeStage executeInst (
        .clk(clk), .rst_n(rst_n),
        .exRd(exRd), .exRegWrite(exRegWrite), .exMemRead(exMemRead),
        .exMemWrite(exMemWrite), .exUseImm(exUseImm), .exAluOp(exAluOp),
        .exImm(exImm), .exShamt(exShamt),
        .exRs1Data(exRs1Data), .exRs2Data(exRs2Data),
        .fwdA(fwdA), .fwdB(fwdB), .wbData(wbData),
        .memAluResult(memAluResult), .memStoreData(memStoreData), .memRd(memRd),
        .memRegWrite(memRegWrite), .memMemRead(memMemRead), .memMemWrite(memMemWrite)
    );

    memStage memInst (
        .clk(clk), .rst_n(rst_n),
        .memAluResult(memAluResult), .memStoreData(memStoreData), .memRd(memRd),
        .memRegWrite(memRegWrite), .memMemRead(memMemRead), .memMemWrite(memMemWrite),
        .dmemAddr(dmemAddr), .dmemWData(dmemWData), .dmemWen(dmemWen),
        .dmemRData(dmemRData),
        .wbData(wbData), .wbRd(wbRd), .wbRegWrite(wbRegWrite)
    );

endmodule

`default_nettype wire

// ==== test/cpu_props.sv ====
`default_nettype none
`include "cpu_consts.svh"

module cpuProps (
    input logic          clk,
    input logic          rst_n,
    input isaPkg::word_t imemAddr,
    input isaPkg::word_t dmemAddr,
    input logic          dmemWen
);

    // -------------------------------------------------------------------------
    // Data memory port
    // -------------------------------------------------------------------------
    wenKnown: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(dmemWen))
        else $error("dmemWen is unknown after reset");

    storeAligned: assert property (@(posedge clk) disable iff (!rst_n)
        dmemWen |-> dmemAddr[1:0] == 2'b00)  // Word stores only
        else $error("store address %h is not word aligned", dmemAddr);

    // -------------------------------------------------------------------------
    // Fetch
    // -------------------------------------------------------------------------
    pcStep: assert property (@(posedge clk) disable iff (!rst_n)
        imemAddr == $past(imemAddr) || imemAddr == $past(imemAddr) + `PC_STEP)
        else $error("imemAddr jumped from %h to %h", $past(imemAddr), imemAddr);

endmodule

// Watch the core ports wherever the core is used
bind cpuCore cpuProps propsInst (
    .clk(clk),
    .rst_n(rst_n),
    .imemAddr(imemAddr),
    .dmemAddr(dmemAddr),
    .dmemWen(dmemWen)
);

`default_nettype wire

// ==== test/cpuTb.sv ====
`default_nettype none
`include "cpu_consts.svh"

module cpuTb;
    import isaPkg::*;

    localparam int    RAND_LEN    = 200;                 // Random part of the program
    localparam int    PROG_LEN    = RAND_LEN + 7;        // Plus the register dump
    localparam int    CYCLE_LIMIT = 3 * (PROG_LEN + 20);
    localparam int    IMEM_WORDS  = 256;
    localparam int    DMEM_WORDS  = 16;
    localparam word_t END_ADDR    = word_t'((PROG_LEN + 5) * `PC_STEP);  // Last store retired

    logic  clk;
    logic  rst_n = 1'b0;
    word_t imemAddr, imemInsn, dmemAddr, dmemWData, dmemRData;
    logic  dmemWen;

    word_t progMem [IMEM_WORDS];
    word_t dmem [DMEM_WORDS];              // Data memory seen by the DUT
    word_t modelMem [DMEM_WORDS];          // Data memory of the ISA model
    word_t modelRegs [`NUM_REGS];
    word_t expAddr [$];                    // Expected stores in program order
    word_t expData [$];
    word_t lcgState = 32'h3504;
    int    storeCount = 0;
    int    cycleCount = 0;

    cpuCore dut_i (
        .clk(clk), .rst_n(rst_n),
        .imemAddr(imemAddr), .imemInsn(imemInsn),
        .dmemAddr(dmemAddr), .dmemWData(dmemWData), .dmemWen(dmemWen),
        .dmemRData(dmemRData)
    );

    // Both memories answer within the cycle
    assign imemInsn  = (imemAddr < IMEM_WORDS * 4) ? progMem[imemAddr[9:2]] : `NOP_INSN;
    assign dmemRData = dmem[dmemAddr[5:2]];

    always @(posedge clk) begin
        if (dmemWen) begin
            dmem[dmemAddr[5:2]] <= dmemWData;
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // -------------------------------------------------------------------------
    // Helpers
    // -------------------------------------------------------------------------
    function automatic word_t nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Odd multiplier mixes in every address bit
    function automatic word_t fillWord(input word_t addr);
        return (addr * 32'h9E37_79B1) ^ 32'h2545_F491;
    endfunction

    function automatic word_t encR(input logic [6:0] f7, input regIdx_t rs2,
                                   input regIdx_t rs1, input logic [2:0] f3,
                                   input regIdx_t rd);
        return {f7, rs2, rs1, f3, rd, opReg};
    endfunction

    function automatic word_t encI(input opcode_t opc, input logic [11:0] imm,
                                   input regIdx_t rs1, input logic [2:0] f3,
                                   input regIdx_t rd);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t encS(input logic [11:0] imm, input regIdx_t rs2,
                                   input regIdx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};  // SW only
    endfunction

    // RV32I ALU semantics with alt from instruction bit 30
    function automatic word_t aluModel(input logic [2:0] f3, input logic alt,
                                       input word_t a, input word_t b,
                                       input logic [4:0] sh);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> sh) : a >> sh;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic abortRun();
        $display("Verification failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkAddr(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %08h actual %08h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkData(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %08h actual %08h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkCount(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("** Error: %s expected %0d actual %0d", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %b actual %b", name, expected, actual);
            abortRun();
        end
    endtask

    // -------------------------------------------------------------------------
    // Program and model
    // -------------------------------------------------------------------------
    task automatic buildProgram();
        word_t       r, s;
        regIdx_t     rd, rs1, rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            progMem[i] = `NOP_INSN;
        end
        for (int i = 0; i < RAND_LEN; i++) begin
            r   = nextRand();
            s   = nextRand();
            rd  = {2'b00, r[27:25]};  // x0 to x7 keeps dependencies dense
            rs1 = {2'b00, r[24:22]};
            rs2 = {2'b00, r[21:19]};
            f3  = r[18:16];
            if (r[31:28] < 4'd5) begin
                f7 = (s[31] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
                progMem[i] = encR(f7, rs2, rs1, f3, rd);
            end else if (r[31:28] < 4'd10) begin
                case (f3)
                    3'b001:  imm = {7'h00, s[26:22]};
                    3'b101:  imm = {1'b0, s[31], 5'b0, s[26:22]};  // SRLI or SRAI
                    default: imm = s[30:19];
                endcase
                progMem[i] = encI(opImm, imm, rs1, f3, rd);
            end else if (r[31:28] < 4'd13) begin
                progMem[i] = encI(opLoad, {6'b0, s[30:27], 2'b00}, 5'd0, 3'b010, rd);
            end else begin
                progMem[i] = encS({6'b0, s[30:27], 2'b00}, rs2, 5'd0);
            end
        end
        // Register dump of xk to word k
        for (int k = 1; k < 8; k++) begin
            progMem[RAND_LEN + k - 1] = encS(12'(k * 4), regIdx_t'(k), 5'd0);
        end
    endtask

    task automatic runModel();
        word_t   insn, a, b, immI, immS, addr, res;
        regIdx_t rd;
        for (int i = 0; i < `NUM_REGS; i++) begin
            modelRegs[i] = '0;
        end
        for (int pc = 0; pc < PROG_LEN; pc++) begin
            insn = progMem[pc];
            rd   = insn[11:7];
            a    = modelRegs[insn[19:15]];
            b    = modelRegs[insn[24:20]];
            immI = {{20{insn[31]}}, insn[31:20]};
            immS = {{20{insn[31]}}, insn[31:25], insn[11:7]};
            res  = '0;
            case (insn[6:0])
                opReg: res = aluModel(insn[14:12], insn[30], a, b, b[4:0]);
                opImm: res = aluModel(insn[14:12], insn[30] && insn[14:12] == 3'b101,
                                      a, immI, insn[24:20]);
                opLoad: begin
                    addr = a + immI;
                    res  = modelMem[addr[5:2]];
                end
                opStore: begin
                    addr = a + immS;
                    modelMem[addr[5:2]] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                end
                default: ;
            endcase
            if (insn[6:0] != opStore && rd != '0) begin  // x0 stays zero
                modelRegs[rd] = res;
            end
        end
    endtask

    // -------------------------------------------------------------------------
    // Store monitor and timeout
    // -------------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst_n && dmemWen) begin
            if (storeCount < expAddr.size()) begin
                checkAddr($sformatf("store %0d address", storeCount),
                          expAddr[storeCount], dmemAddr);
                checkData($sformatf("store %0d data", storeCount),
                          expData[storeCount], dmemWData);
            end
            storeCount <= storeCount + 1;  // Extra stores caught by the count
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: program did not finish within %0d cycles", CYCLE_LIMIT);
            abortRun();
        end
    end

    initial begin
        buildProgram();
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] <= fillWord(i * 4);
            modelMem[i] = fillWord(i * 4);
        end
        runModel();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // First fetches before any load can stall
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            checkAddr($sformatf("fetch step %0d", i), word_t'(i * `PC_STEP), imemAddr);
            checkFlag($sformatf("dmemWen at step %0d", i), 1'b0, dmemWen);
        end

        while (imemAddr < END_ADDR) begin
            @(posedge clk);
        end
        checkCount("store count", expAddr.size(), storeCount);
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
common/isaPkg.sv
common/pipePkg.sv
execute/alu.sv
execute/executeStage.sv
decode/regFile.sv
decode/decodeStage.sv
rtl/hazardUnit.sv
rtl/memStage.sv
rtl/cpuCore.sv
test/cpu_props.sv
test/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the run by the log
rm -f sim.log
verilator --binary --timing --assert --top-module cpuTb -f verilog.f -o cpuSim \
    && ./obj_dir/cpuSim | tee sim.log
grep -q "^Verification passed$" sim.log 2>/dev/null \
    && echo "Simulation run passed" \
    || { echo "Simulation run failed"; exit 1; }
